// ==== change_dispenser.sv ====
`timescale 1ns/100ps

module change_dispenser
    import vend_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   change_load,
    input  money_t change_amount,
    output coin_t  coin_to_return,
    output money_t remaining,
    output logic   change_done
);

    money_t remaining_q;
    coin_t  coin_next;

    ////////////////////
    // Greedy coin pick
    ////////////////////

    // Largest coin that still fits
    always_comb begin
        if (remaining_q >= coin_value(dollar)) begin
            coin_next = dollar;
        end else if (remaining_q >= coin_value(cent50)) begin
            coin_next = cent50;
        end else if (remaining_q >= coin_value(cent25)) begin
            coin_next = cent25;
        end else if (remaining_q >= coin_value(cent10)) begin
            coin_next = cent10;
        end else if (remaining_q >= coin_value(cent5)) begin
            coin_next = cent5;
        end else if (remaining_q != '0) begin
            coin_next = cent1;
        end else begin
            coin_next = none;                 // Nothing owed
        end
    end

    ////////////////////
    // Remaining amount
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            remaining_q <= '0;
        end else if (change_load) begin
            remaining_q <= change_amount;
        end else if (remaining_q != '0) begin
            remaining_q <= remaining_q - coin_value(coin_next);   // One coin per cycle
        end
    end

    assign coin_to_return = coin_next;
    assign remaining      = remaining_q;
    assign change_done    = (remaining_q == '0);

endmodule

// ==== coin_accumulator.sv ====
`timescale 1ns/100ps

module coin_accumulator
    import vend_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  coin_t  coin,
    input  logic   count_enable,
    input  logic   credit_clear,
    output money_t credit
);

    money_t coin_cents;
    money_t credit_q;

    ////////////////////
    // Coin decode
    ////////////////////

    // Invalid code maps to zero
    always_comb begin
        coin_cents = coin_value(coin);
    end

    ////////////////////
    // Credit register
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit_q <= '0;
        end else if (credit_clear) begin
            credit_q <= '0;                   // Clear wins over a coin
        end else if (count_enable) begin
            credit_q <= credit_q + coin_cents;
        end
    end

    assign credit = credit_q;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_vending_machine -o sim_vending

output=$(./obj_dir/sim_vending)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi

// ==== selection_decoder.sv ====
`timescale 1ns/100ps
`include "vend_macros.svh"

module selection_decoder
    import vend_pkg::*;
(
    input  keypad_t    keypad,
    output selection_t selection
);

    localparam int IDX_W = $clog2(`COLS);

    logic [IDX_W-1:0] row_idx;
    logic [IDX_W-1:0] col_idx;
    logic             any_row;
    logic             any_col;
    money_t           row_price;

    // Index of the lowest set bit, lowest wins
    function automatic logic [IDX_W-1:0] lowest_index(input logic [`COLS-1:0] bits);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = `COLS - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////
    // Priority encode
    ////////////////////

    assign any_row = |keypad.row;
    assign any_col = |keypad.col;
    assign row_idx = lowest_index(`COLS'(keypad.row));   // Row field is narrower
    assign col_idx = lowest_index(keypad.col);

    ////////////////////
    // Row price
    ////////////////////

    always_comb begin
        case (row_idx)
            IDX_W'(0): row_price = `PRICE_A;
            IDX_W'(1): row_price = `PRICE_B;
            IDX_W'(2): row_price = `PRICE_C;
            default:   row_price = `PRICE_D;
        endcase
    end

    // A1 is slot 1, D5 is slot 20
    always_comb begin
        selection.valid = any_row && any_col;
        selection.slot  = slot_t'(row_idx * `COLS + col_idx + 1);
        selection.price = row_price;
    end

endmodule

// ==== tb.f ====
+incdir+.
vend_pkg.sv
coin_accumulator.sv
selection_decoder.sv
change_dispenser.sv
vend_controller.sv
vending_machine.sv
vend_props.sv
tb_vending_machine.sv

// ==== tb_vending_machine.sv ====
`timescale 1ns/100ps
`include "vend_macros.svh"

module tb_vending_machine
    import vend_pkg::*;
();

    typedef struct packed {
        logic [7:0][2:0] coins;               // coins[7] goes in first, none ends the list
        keypad_t         keys;
        slot_t           slot;
        money_t          change;
    } vector_t;

    logic    clock;
    logic    reset;
    keypad_t keypad;
    coin_t   coin;
    logic    food_dispensed;
    slot_t   food_selection;
    coin_t   coin_to_return;
    money_t  credit_display;

    vector_t     vectors [0:7];
    coin_t       coin_seq [$];
    money_t      model_credit;
    logic [31:0] rng_state;
    int          mismatch_count;
    int          failure_count;

    vending_machine vending_machine_inst (
        .clock          (clock),
        .reset          (reset),
        .keypad         (keypad),
        .coin           (coin),
        .food_dispensed (food_dispensed),
        .food_selection (food_selection),
        .coin_to_return (coin_to_return),
        .credit_display (credit_display)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic money_t cents_of(input coin_t c);
        case (c)
            cent1:   return `COIN_1C;
            cent5:   return `COIN_5C;
            cent10:  return `COIN_10C;
            cent25:  return `COIN_25C;
            cent50:  return `COIN_50C;
            dollar:  return `COIN_100C;
            default: return '0;
        endcase
    endfunction

    function automatic coin_t greedy_coin(input money_t owed);
        if (owed >= `COIN_100C) return dollar;
        if (owed >= `COIN_50C) return cent50;
        if (owed >= `COIN_25C) return cent25;
        if (owed >= `COIN_10C) return cent10;
        if (owed >= `COIN_5C) return cent5;
        if (owed != '0) return cent1;
        return none;
    endfunction

    function automatic int lowest_bit(input logic [4:0] bits);
        int idx;
        idx = 0;
        for (int i = 4; i >= 0; i--) begin
            if (bits[i]) idx = i;
        end
        return idx;
    endfunction

    function automatic slot_t slot_for(input keypad_t k);
        return slot_t'(lowest_bit({1'b0, k.row}) * `COLS + lowest_bit(k.col) + 1);
    endfunction

    function automatic money_t price_for(input keypad_t k);
        case (lowest_bit({1'b0, k.row}))
            0:       return `PRICE_A;
            1:       return `PRICE_B;
            2:       return `PRICE_C;
            default: return `PRICE_D;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic vector_t make_vector(input logic [7:0][2:0] coins,
                                            input logic [3:0] row, input logic [4:0] col,
                                            input slot_t slot, input money_t change);
        vector_t v;
        v.coins    = coins;
        v.keys.row = row;
        v.keys.col = col;
        v.slot     = slot;
        v.change   = change;
        return v;
    endfunction

    ////////////////////
    // Checks and stimulus
    ////////////////////

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic fill_vectors();
        vectors[0] = make_vector({dollar, none, none, none, none, none, none, none},
                                 4'b0001, 5'b00001, 5'd1, 10'd0);
        vectors[1] = make_vector({cent50, cent50, 3'd7, cent25, none, none, none, none},
                                 4'b0010, 5'b10000, 5'd10, 10'd0);
        vectors[2] = make_vector({dollar, dollar, none, none, none, none, none, none},
                                 4'b1000, 5'b00100, 5'd18, 10'd25);
        vectors[3] = make_vector({cent10, cent5, cent1, dollar, cent50, none, none, none},
                                 4'b1100, 5'b10110, 5'd12, 10'd16);   // Lowest row and column
        vectors[4] = make_vector({dollar, dollar, none, none, none, none, none, none},
                                 4'b0100, 5'b10000, 5'd15, 10'd50);
        vectors[5] = make_vector({cent25, cent25, cent25, dollar, none, none, none, none},
                                 4'b1001, 5'b11111, 5'd1, 10'd75);
        vectors[6] = make_vector({dollar, cent50, cent1, cent25, none, none, none, none},
                                 4'b1000, 5'b00001, 5'd16, 10'd1);
        vectors[7] = make_vector({cent50, cent10, dollar, none, none, none, none, none},
                                 4'b0001, 5'b00010, 5'd2, 10'd60);
    endtask

    task automatic load_coins(input int n);
        logic ended;
        ended = 1'b0;
        coin_seq.delete();
        for (int i = 7; i >= 0; i--) begin
            if (vectors[n].coins[i] == 3'd0) ended = 1'b1;
            if (!ended) coin_seq.push_back(coin_t'(vectors[n].coins[i]));
        end
    endtask

    // Credit moves one edge after the coin is sampled
    task automatic insert_coin(input coin_t c);
        @(posedge clock);
        coin <= c;
        @(negedge clock);
        check_value("credit_display", int'(credit_display), int'(model_credit));
        @(posedge clock);
        coin <= none;
        model_credit = model_credit + cents_of(c);
        @(negedge clock);
        check_value("credit_display", int'(credit_display), int'(model_credit));
    endtask

    task automatic wait_for_slot(output logic seen);
        seen = 1'b0;
        for (int cycles = 0; cycles < 10 && !seen; cycles++) begin
            @(negedge clock);
            if (food_selection != '0) seen = 1'b1;
        end
    endtask

    task automatic run_vector(input keypad_t keys, input slot_t exp_slot,
                              input money_t exp_change);
        money_t price;
        money_t owed;
        money_t paid;
        coin_t  expect_coin;
        logic   seen;
        logic   done;
        price = price_for(keys);
        @(posedge clock);
        keypad <= keys;
        foreach (coin_seq[i]) begin
            insert_coin(coin_seq[i]);
            if (model_credit < price) begin
                repeat (2) @(negedge clock);
                check_value("food_selection", int'(food_selection), 0);
                check_value("credit_display", int'(credit_display), int'(model_credit));
            end
        end
        wait_for_slot(seen);
        if (!seen) begin
            failure_count++;
            $display("Timeout at %0t: no slot was selected with enough credit", $time);
        end
        check_value("food_selection", int'(food_selection), int'(exp_slot));
        @(posedge clock);
        keypad <= '0;
        coin <= dollar;                       // Not counted while vending
        @(posedge clock);
        coin <= cent25;
        @(posedge clock);
        coin <= none;
        @(negedge clock);
        check_value("food_selection", int'(food_selection), int'(exp_slot));
        check_value("credit_display", int'(credit_display), int'(model_credit));
        @(posedge clock);
        food_dispensed <= 1'b1;
        coin <= dollar;
        @(posedge clock);
        food_dispensed <= 1'b0;
        coin <= cent50;                       // Lands in the change state
        owed = exp_change;
        paid = '0;
        done = 1'b0;
        for (int cycles = 0; cycles < 16 && !done; cycles++) begin
            @(negedge clock);
            expect_coin = greedy_coin(owed);
            check_value("food_selection", int'(food_selection), 0);
            check_value("credit_display", int'(credit_display), int'(owed));
            check_value("coin_to_return", int'(coin_to_return), int'(expect_coin));
            if (coin_to_return == none) begin
                done = 1'b1;
            end else begin
                paid = paid + cents_of(coin_to_return);
                owed = owed - cents_of(expect_coin);
            end
            @(posedge clock);
            coin <= none;
        end
        if (!done) begin
            failure_count++;
            $display("Timeout at %0t: change payout did not finish", $time);
        end
        check_value("change paid", int'(paid), int'(exp_change));
        @(negedge clock);
        check_value("credit_display", int'(credit_display), 0);
        check_value("coin_to_return", int'(coin_to_return), int'(none));
        model_credit = '0;
    endtask

    task automatic run_random_vectors();
        keypad_t keys;
        money_t  total;
        coin_t   c;
        rng_state = 32'd96702;
        for (int n = 0; n < 6; n++) begin
            rng_state = xorshift32(rng_state);
            keys.row = (rng_state[3:0] == 4'd0) ? 4'b1000 : rng_state[3:0];
            keys.col = (rng_state[8:4] == 5'd0) ? 5'b00100 : rng_state[8:4];
            total = '0;
            coin_seq.delete();
            while (total < price_for(keys)) begin
                rng_state = xorshift32(rng_state);
                c = coin_t'(3'(3 + rng_state % 5));   // Ten cents up to code 7
                coin_seq.push_back(c);
                total = total + cents_of(c);
            end
            run_vector(keys, slot_for(keys), total - price_for(keys));
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        reset = 1'b1;
        keypad = '0;
        coin = none;
        food_dispensed = 1'b0;
        mismatch_count = 0;
        failure_count = 0;
        model_credit = '0;
        fill_vectors();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("credit_display", int'(credit_display), 0);
        check_value("food_selection", int'(food_selection), 0);
        check_value("coin_to_return", int'(coin_to_return), int'(none));
        for (int n = 0; n < 8; n++) begin
            load_coins(n);
            run_vector(vectors[n].keys, vectors[n].slot, vectors[n].change);
        end
        run_random_vectors();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vend_controller.sv ====
`timescale 1ns/100ps

module vend_controller
    import vend_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  selection_t selection,
    input  money_t     credit,
    input  logic       food_dispensed,
    input  logic       change_done,
    input  money_t     remaining,
    output slot_t      food_selection,
    output logic       count_enable,
    output logic       credit_clear,
    output logic       change_load,
    output money_t     change_amount,
    output money_t     credit_display
);

    vend_state_t state_q;
    slot_t       slot_q;
    money_t      price_q;
    logic        accept;
    logic        dropped;

    ////////////////////
    // Decisions
    ////////////////////

    // Enough credit for the pressed slot
    assign accept = (state_q == collect) && selection.valid &&
                    (credit >= selection.price);

    // Sensor saw the item fall
    assign dropped = (state_q == vend) && food_dispensed;

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= collect;
            slot_q  <= '0;
        end else begin
            case (state_q)
                collect: begin
                    if (accept) begin
                        state_q <= vend;
                        slot_q  <= selection.slot;
                    end
                end
                vend: begin
                    if (dropped) begin
                        state_q <= change;
                        slot_q  <= '0;        // Release the slot motor
                    end
                end
                change: begin
                    if (change_done) begin
                        state_q <= collect;
                    end
                end
                default: begin
                    state_q <= collect;
                    slot_q  <= '0;
                end
            endcase
        end
    end

    // Price of the accepted slot
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            price_q <= '0;
        end else if (accept) begin
            price_q <= selection.price;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign food_selection = slot_q;
    assign count_enable   = (state_q == collect);   // Coins ignored while busy
    assign credit_clear   = dropped;
    assign change_load    = dropped;
    assign change_amount  = credit - price_q;

    // Countdown of change while paying out
    assign credit_display = (state_q == change) ? remaining : credit;

endmodule

// ==== vend_macros.svh ====
`ifndef VEND_MACROS_SVH
`define VEND_MACROS_SVH

////////////////////
// Money
////////////////////

`define MONEY_W 10                   // Cents, up to 1023

////////////////////
// Slot grid
////////////////////

`define ROWS 4                       // Rows A to D
`define COLS 5                       // Columns 1 to 5

// Price per row in cents
`define PRICE_A (`MONEY_W'(100))
`define PRICE_B (`MONEY_W'(125))
`define PRICE_C (`MONEY_W'(150))
`define PRICE_D (`MONEY_W'(175))

////////////////////
// Coin values
////////////////////

`define COIN_1C   (`MONEY_W'(1))
`define COIN_5C   (`MONEY_W'(5))
`define COIN_10C  (`MONEY_W'(10))
`define COIN_25C  (`MONEY_W'(25))
`define COIN_50C  (`MONEY_W'(50))
`define COIN_100C (`MONEY_W'(100))

`endif

// ==== vend_pkg.sv ====
`include "vend_macros.svh"

package vend_pkg;

    typedef logic [`MONEY_W-1:0] money_t;     // Amount in cents

    // Code 7 is not a coin
    typedef enum logic [2:0] {
        none   = 3'd0,
        cent1  = 3'd1,
        cent5  = 3'd2,
        cent10 = 3'd3,
        cent25 = 3'd4,
        cent50 = 3'd5,
        dollar = 3'd6
    } coin_t;

    typedef logic [4:0] slot_t;               // 0 is no selection

    typedef struct packed {
        logic [`ROWS-1:0] row;                // One-hot, bit 0 is row A
        logic [`COLS-1:0] col;                // One-hot, bit 0 is column 1
    } keypad_t;

    typedef struct packed {
        logic   valid;
        slot_t  slot;
        money_t price;
    } selection_t;

    typedef enum logic [1:0] {
        collect = 2'd0,
        vend    = 2'd1,
        change  = 2'd2
    } vend_state_t;

    // Value in cents of a coin code
    function automatic money_t coin_value(input coin_t c);
        case (c)
            cent1:   return `COIN_1C;
            cent5:   return `COIN_5C;
            cent10:  return `COIN_10C;
            cent25:  return `COIN_25C;
            cent50:  return `COIN_50C;
            dollar:  return `COIN_100C;
            default: return '0;               // none and code 7
        endcase
    endfunction

endpackage

// ==== vend_props.sv ====
`timescale 1ns/100ps

module vend_props
    import vend_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input vend_state_t state,
    input slot_t       food_selection,
    input logic        change_load,
    input logic        credit_clear,
    input money_t      credit,
    input money_t      remaining,
    input money_t      change_amount
);

    ////////////////////
    // Payout start
    ////////////////////

    load_single_cycle: assert property (
        @(posedge clock) disable iff (reset) change_load |=> !change_load
    ) else $error("change_load stayed high for more than one cycle");

    // Credit is emptied on the same edge the dispenser takes the change
    clear_with_load: assert property (
        @(posedge clock) disable iff (reset)
        credit_clear |=> (credit == '0) && (remaining == $past(change_amount))
    ) else $error("credit was not cleared together with the change load");

    ////////////////////
    // Slot output
    ////////////////////

    slot_idle_outside_vend: assert property (
        @(posedge clock) disable iff (reset) (state != vend) |-> (food_selection == '0)
    ) else $error("food_selection is nonzero outside the vend state");

endmodule

bind vend_controller vend_props vend_props_inst (
    .clock          (clock),
    .reset          (reset),
    .state          (state_q),
    .food_selection (food_selection),
    .change_load    (change_load),
    .credit_clear   (credit_clear),
    .credit         (credit),
    .remaining      (remaining),
    .change_amount  (change_amount)
);

// ==== vending_machine.sv ====
`timescale 1ns/100ps

module vending_machine
    import vend_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  keypad_t keypad,
    input  coin_t   coin,
    input  logic    food_dispensed,
    output slot_t   food_selection,
    output coin_t   coin_to_return,
    output money_t  credit_display
);

    selection_t selection;
    money_t     credit;
    logic       count_enable;
    logic       credit_clear;
    logic       change_load;
    money_t     change_amount;
    money_t     remaining;
    logic       change_done;

    ////////////////////
    // Front end
    ////////////////////

    coin_accumulator coin_accumulator_inst (
        .clock        (clock),
        .reset        (reset),
        .coin         (coin),
        .count_enable (count_enable),
        .credit_clear (credit_clear),
        .credit       (credit)
    );

    selection_decoder selection_decoder_inst (
        .keypad    (keypad),
        .selection (selection)
    );

    ////////////////////
    // Control and payout
    ////////////////////

    vend_controller vend_controller_inst (
        .clock          (clock),
        .reset          (reset),
        .selection      (selection),
        .credit         (credit),
        .food_dispensed (food_dispensed),
        .change_done    (change_done),
        .remaining      (remaining),
        .food_selection (food_selection),
        .count_enable   (count_enable),
        .credit_clear   (credit_clear),
        .change_load    (change_load),
        .change_amount  (change_amount),
        .credit_display (credit_display)
    );

    change_dispenser change_dispenser_inst (
        .clock          (clock),
        .reset          (reset),
        .change_load    (change_load),
        .change_amount  (change_amount),
        .coin_to_return (coin_to_return),
        .remaining      (remaining),
        .change_done    (change_done)
    );

endmodule
